// ==== hw/lsu_consts.svh ====
/*
 * widths and limits shared by the load/store unit
 * data bus width, byte enables, outstanding depth, stream length
 */

`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// bus data and address width
`define LSU_DATA_W 32

// one enable per byte lane
`define LSU_BE_W 4

`define LSU_DEPTH 2  // max outstanding bus transactions
`define LSU_CNT_W 2  // wide enough to hold LSU_DEPTH

// stream word count width
`define LSU_LEN_W 16

`endif

// ==== hw/lsu_pkg.sv ====
/*
 * load/store unit types
 * access size, load extension mode, stream FSM states
 */

package lsu_pkg;

  // access size as decoded by the execute stage
  typedef enum logic [1:0] {
    SIZE_WORD = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_BYTE = 2'b10
  } size_e;

  // how the upper bits of a narrow load are filled
  typedef enum logic [1:0] {
    EXT_ZERO = 2'b00,  // zero fill
    EXT_SIGN = 2'b01,  // copy msb of the loaded lane
    EXT_ONES = 2'b10   // fill with ones
  } ext_e;

  // stream address generator states
  typedef enum logic [1:0] {
    ST_IDLE  = 2'b00,
    ST_ISSUE = 2'b01,  // requesting words
    ST_DRAIN = 2'b10   // all issued, waiting for returns
  } stream_state_e;

endpackage

// ==== hw/lsu_bus_if.sv ====
/*
 * one requester's view of the shared data bus
 * requester and arbiter modports
 */

`include "lsu_consts.svh"

interface lsu_bus_if;

  // address phase, driven by the requester
  logic                   req;
  logic [`LSU_DATA_W-1:0] addr;
  logic                   we;
  logic [`LSU_BE_W-1:0]   be;
  logic [`LSU_DATA_W-1:0] wdata;

  // grant and response phase, driven by the arbiter
  logic                   gnt;
  logic                   rvalid;
  logic [`LSU_DATA_W-1:0] rdata;

  modport requester (
    output req, addr, we, be, wdata,
    input  gnt, rvalid, rdata
  );

  modport arbiter (
    input  req, addr, we, be, wdata,
    output gnt, rvalid, rdata
  );

endinterface

// ==== hw/lsu_core_port.sv ====
/*
 * execute-stage access path of the load/store unit
 * address gen, byte enables, store rotation, misalign check, load extraction
 */

`include "lsu_consts.svh"

module lsu_core_port (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   ex_req_i,
  input  logic                   ex_we_i,
  input  logic                   addr_incr_i,
  input  lsu_pkg::size_e         ex_size_i,
  input  lsu_pkg::ext_e          ex_ext_i,
  input  logic [`LSU_DATA_W-1:0] op_a_i,
  input  logic [`LSU_DATA_W-1:0] op_b_i,
  input  logic [`LSU_DATA_W-1:0] ex_wdata_i,
  input  logic [1:0]             reg_offset_i,
  output logic                   ready_ex_o,
  output logic                   misaligned_o,
  output logic                   wb_valid_o,
  output logic [`LSU_DATA_W-1:0] wb_rdata_o,
  lsu_bus_if.requester           bus
);

  logic [`LSU_DATA_W-1:0] addr;
  logic [1:0]             wdata_offset;
  logic                   pend_q;        // one access in flight from this port
  logic                   accept;

  // captured at acceptance for the response
  lsu_pkg::size_e         size_q;
  lsu_pkg::ext_e          ext_q;
  logic [1:0]             offset_q;
  logic                   we_q;

  logic [`LSU_DATA_W-1:0] lane;          // response shifted down to the addressed lane
  logic                   fill_h;
  logic                   fill_b;

  ////////////////////////////////////////////////////////////
  // address phase

  assign addr = addr_incr_i ? (op_a_i + op_b_i) : op_a_i;

  // word needs offset 0, half must not straddle the word
  assign misaligned_o = ex_req_i &&
                        (((ex_size_i == lsu_pkg::SIZE_WORD) && (addr[1:0] != 2'b00)) ||
                         ((ex_size_i == lsu_pkg::SIZE_HALF) && (addr[1:0] == 2'b11)));

  assign bus.req  = ex_req_i && !misaligned_o && !pend_q;  // wait for previous response
  assign bus.addr = addr;
  assign bus.we   = ex_we_i;
  assign accept   = bus.req && bus.gnt;

  assign ready_ex_o = !ex_req_i || misaligned_o || accept;

  always_comb begin
    case (ex_size_i)
      lsu_pkg::SIZE_WORD: bus.be = 4'b1111;
      lsu_pkg::SIZE_HALF: bus.be = 4'b0011 << addr[1:0];  // offsets 0..2 only
      default:            bus.be = 4'b0001 << addr[1:0];
    endcase
  end

  // rotate register lanes onto memory lanes
  assign wdata_offset = addr[1:0] - reg_offset_i;

  always_comb begin
    case (wdata_offset)
      2'b00:   bus.wdata = ex_wdata_i;
      2'b01:   bus.wdata = {ex_wdata_i[23:0], ex_wdata_i[31:24]};
      2'b10:   bus.wdata = {ex_wdata_i[15:0], ex_wdata_i[31:16]};
      default: bus.wdata = {ex_wdata_i[7:0], ex_wdata_i[31:8]};
    endcase
  end

  ////////////////////////////////////////////////////////////
  // response phase

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      pend_q <= 1'b0;
    end else if (accept) begin
      pend_q <= 1'b1;
    end else if (bus.rvalid) begin
      pend_q <= 1'b0;  // never both, accept needs !pend_q
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      size_q   <= ex_size_i;
      ext_q    <= ex_ext_i;
      offset_q <= addr[1:0];
      we_q     <= ex_we_i;
    end
  end

  assign lane = bus.rdata >> {offset_q, 3'b000};

  always_comb begin
    case (ext_q)
      lsu_pkg::EXT_SIGN: begin
        fill_h = lane[15];
        fill_b = lane[7];
      end
      lsu_pkg::EXT_ONES: begin
        fill_h = 1'b1;
        fill_b = 1'b1;
      end
      default: begin  // zero extension
        fill_h = 1'b0;
        fill_b = 1'b0;
      end
    endcase
  end

  always_comb begin
    case (size_q)
      lsu_pkg::SIZE_WORD: wb_rdata_o = bus.rdata;  // always aligned here
      lsu_pkg::SIZE_HALF: wb_rdata_o = {{16{fill_h}}, lane[15:0]};
      default:            wb_rdata_o = {{24{fill_b}}, lane[7:0]};
    endcase
  end

  assign wb_valid_o = bus.rvalid && !we_q;  // stores end silently

  // misaligned accesses never reach the bus
  a_no_req_misaligned : assert property (@(posedge clk) disable iff (!rst_n)
    misaligned_o |-> !bus.req);

  // arbiter routes a response here only for our own access
  a_rvalid_owned : assert property (@(posedge clk) disable iff (!rst_n)
    bus.rvalid |-> pend_q);

endmodule

// ==== hw/lsu_stream_gen.sv ====
/*
 * streaming word-read address generator
 * run counters against a latched length, issue/drain FSM
 */

`include "lsu_consts.svh"

module lsu_stream_gen (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   stream_start_i,
  input  logic [`LSU_DATA_W-1:0] stream_base_i,
  input  logic [`LSU_LEN_W-1:0]  stream_len_i,
  output logic                   stream_rvalid_o,
  output logic                   stream_done_o,
  output logic [`LSU_DATA_W-1:0] stream_rdata_o,
  lsu_bus_if.requester           bus
);

  lsu_pkg::stream_state_e state_q, state_d;
  logic [`LSU_LEN_W-1:0]  len_q;
  logic [`LSU_LEN_W-1:0]  issue_cnt_q;   // reads accepted so far
  logic [`LSU_LEN_W-1:0]  ret_cnt_q;     // words returned so far
  logic [`LSU_DATA_W-1:0] addr_q;
  logic                   done_q;
  logic                   start;
  logic                   accept;
  logic                   last_issue;
  logic                   last_ret;

  assign start      = stream_start_i && (state_q == lsu_pkg::ST_IDLE);
  assign accept     = bus.req && bus.gnt;
  assign last_issue = accept && (issue_cnt_q + 1'b1 == len_q);
  assign last_ret   = bus.rvalid && (ret_cnt_q + 1'b1 == len_q);

  always_comb begin
    state_d = state_q;
    case (state_q)
      lsu_pkg::ST_IDLE:  if (start && (stream_len_i != '0)) state_d = lsu_pkg::ST_ISSUE;
      lsu_pkg::ST_ISSUE: if (last_issue) state_d = lsu_pkg::ST_DRAIN;
      lsu_pkg::ST_DRAIN: if (last_ret) state_d = lsu_pkg::ST_IDLE;
      default:           state_d = lsu_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= lsu_pkg::ST_IDLE;
      issue_cnt_q <= '0;
      ret_cnt_q   <= '0;
      done_q      <= 1'b0;
    end else begin
      state_q <= state_d;
      // empty run finishes at once, otherwise on the last return
      done_q  <= (start && (stream_len_i == '0)) ||
                 ((state_q == lsu_pkg::ST_DRAIN) && last_ret);
      if (start) begin
        issue_cnt_q <= '0;
        ret_cnt_q   <= '0;
      end else begin
        if (accept) issue_cnt_q <= issue_cnt_q + 1'b1;
        if (bus.rvalid) ret_cnt_q <= ret_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      len_q  <= stream_len_i;
      addr_q <= stream_base_i;
    end else if (accept) begin
      addr_q <= addr_q + `LSU_DATA_W'(4);  // next word
    end
  end

  // word reads only
  assign bus.req   = (state_q == lsu_pkg::ST_ISSUE);
  assign bus.addr  = addr_q;
  assign bus.we    = 1'b0;
  assign bus.be    = '1;
  assign bus.wdata = '0;

  assign stream_rvalid_o = bus.rvalid;
  assign stream_rdata_o  = bus.rdata;
  assign stream_done_o   = done_q;

endmodule

// ==== hw/lsu_bus_arbiter.sv ====
/*
 * fixed-priority arbiter for the shared data bus
 * outstanding counter, owner queue, in-order response routing
 */

`include "lsu_consts.svh"

module lsu_bus_arbiter (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   data_gnt_i,
  input  logic                   data_rvalid_i,
  input  logic [`LSU_DATA_W-1:0] data_rdata_i,
  output logic                   data_req_o,
  output logic                   data_we_o,
  output logic                   busy_o,
  output logic [`LSU_DATA_W-1:0] data_addr_o,
  output logic [`LSU_DATA_W-1:0] data_wdata_o,
  output logic [`LSU_BE_W-1:0]   data_be_o,
  lsu_bus_if.arbiter             core_bus,
  lsu_bus_if.arbiter             stream_bus
);

  logic [`LSU_CNT_W-1:0] cnt_q, next_cnt;
  logic                  count_up;
  logic                  count_down;
  logic                  can_issue;
  logic                  sel_core;
  logic                  lock_q;         // address phase waiting for gnt
  logic                  lock_core_q;    // owner of that address phase
  logic [`LSU_DEPTH-1:0] owner_q;        // 1 = core, 0 = stream
  logic                  wr_ptr_q;
  logic                  rd_ptr_q;
  logic                  head_core;

  ////////////////////////////////////////////////////////////
  // request side

  // full unless a response frees a slot this cycle
  assign can_issue = (cnt_q != `LSU_CNT_W'(`LSU_DEPTH)) || data_rvalid_i;

  // core wins, but an ungranted phase keeps its owner
  assign sel_core = lock_q ? lock_core_q : core_bus.req;

  assign data_req_o   = (sel_core ? core_bus.req : stream_bus.req) && can_issue;
  assign data_addr_o  = sel_core ? core_bus.addr  : stream_bus.addr;
  assign data_we_o    = sel_core ? core_bus.we    : stream_bus.we;
  assign data_be_o    = sel_core ? core_bus.be    : stream_bus.be;
  assign data_wdata_o = sel_core ? core_bus.wdata : stream_bus.wdata;

  assign core_bus.gnt   = data_gnt_i && data_req_o && sel_core;
  assign stream_bus.gnt = data_gnt_i && data_req_o && !sel_core;

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      lock_q      <= 1'b0;
      lock_core_q <= 1'b0;
    end else begin
      lock_q      <= data_req_o && !data_gnt_i;
      lock_core_q <= sel_core;
    end
  end

  ////////////////////////////////////////////////////////////
  // outstanding counter

  assign count_up   = data_req_o && data_gnt_i;
  assign count_down = data_rvalid_i;

  always_comb begin
    unique case ({count_up, count_down})
      2'b10:   next_cnt = cnt_q + 1'b1;
      2'b01:   next_cnt = cnt_q - 1'b1;
      default: next_cnt = cnt_q;  // idle, or one in and one out
    endcase
  end

  ////////////////////////////////////////////////////////////
  // owner queue and response routing

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      cnt_q    <= '0;
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
    end else begin
      cnt_q <= next_cnt;
      if (count_up) wr_ptr_q <= !wr_ptr_q;
      if (count_down) rd_ptr_q <= !rd_ptr_q;
    end
  end

  always_ff @(posedge clk) begin
    if (count_up) owner_q[wr_ptr_q] <= sel_core;
  end

  assign head_core = owner_q[rd_ptr_q];  // oldest outstanding

  assign core_bus.rvalid   = data_rvalid_i && head_core;
  assign stream_bus.rvalid = data_rvalid_i && !head_core;
  assign core_bus.rdata    = data_rdata_i;
  assign stream_bus.rdata  = data_rdata_i;

  assign busy_o = (cnt_q != '0) || core_bus.req || stream_bus.req;

  a_cnt_max : assert property (@(posedge clk) disable iff (!rst_n)
    cnt_q <= `LSU_CNT_W'(`LSU_DEPTH));

  a_no_spurious_rvalid : assert property (@(posedge clk) disable iff (!rst_n)
    data_rvalid_i |-> (cnt_q != '0));

  a_addr_phase_known : assert property (@(posedge clk) disable iff (!rst_n)
    data_req_o |-> !$isunknown({data_addr_o, data_we_o, data_be_o}));

endmodule

// ==== hw/load_store_unit.sv ====
/*
 * load/store unit top level
 * core port and stream generator sharing one data bus via the arbiter
 */

`include "lsu_consts.svh"

module load_store_unit (
  input  logic                   clk,
  input  logic                   rst_n,
  // execute stage
  input  logic                   ex_req_i,
  input  logic                   ex_we_i,
  input  logic                   addr_incr_i,
  input  lsu_pkg::size_e         ex_size_i,
  input  lsu_pkg::ext_e          ex_ext_i,
  input  logic [`LSU_DATA_W-1:0] op_a_i,
  input  logic [`LSU_DATA_W-1:0] op_b_i,
  input  logic [`LSU_DATA_W-1:0] ex_wdata_i,
  input  logic [1:0]             reg_offset_i,
  output logic                   ready_ex_o,
  output logic                   misaligned_o,
  // write-back
  output logic                   wb_valid_o,
  output logic [`LSU_DATA_W-1:0] wb_rdata_o,
  // stream requester
  input  logic                   stream_start_i,
  input  logic [`LSU_DATA_W-1:0] stream_base_i,
  input  logic [`LSU_LEN_W-1:0]  stream_len_i,
  output logic                   stream_rvalid_o,
  output logic                   stream_done_o,
  output logic [`LSU_DATA_W-1:0] stream_rdata_o,
  // data bus
  output logic                   data_req_o,
  input  logic                   data_gnt_i,
  input  logic                   data_rvalid_i,
  output logic [`LSU_DATA_W-1:0] data_addr_o,
  output logic                   data_we_o,
  output logic [`LSU_BE_W-1:0]   data_be_o,
  output logic [`LSU_DATA_W-1:0] data_wdata_o,
  input  logic [`LSU_DATA_W-1:0] data_rdata_i,
  output logic                   busy_o
);

  lsu_bus_if core_bus ();    // core port side
  lsu_bus_if stream_bus ();  // stream side

  lsu_core_port i_core_port (
    .clk          (clk),
    .rst_n        (rst_n),
    .ex_req_i     (ex_req_i),
    .ex_we_i      (ex_we_i),
    .addr_incr_i  (addr_incr_i),
    .ex_size_i    (ex_size_i),
    .ex_ext_i     (ex_ext_i),
    .op_a_i       (op_a_i),
    .op_b_i       (op_b_i),
    .ex_wdata_i   (ex_wdata_i),
    .reg_offset_i (reg_offset_i),
    .ready_ex_o   (ready_ex_o),
    .misaligned_o (misaligned_o),
    .wb_valid_o   (wb_valid_o),
    .wb_rdata_o   (wb_rdata_o),
    .bus          (core_bus.requester)
  );

  lsu_stream_gen i_stream_gen (
    .clk             (clk),
    .rst_n           (rst_n),
    .stream_start_i  (stream_start_i),
    .stream_base_i   (stream_base_i),
    .stream_len_i    (stream_len_i),
    .stream_rvalid_o (stream_rvalid_o),
    .stream_done_o   (stream_done_o),
    .stream_rdata_o  (stream_rdata_o),
    .bus             (stream_bus.requester)
  );

  lsu_bus_arbiter i_bus_arbiter (
    .clk           (clk),
    .rst_n         (rst_n),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .data_rdata_i  (data_rdata_i),
    .data_req_o    (data_req_o),
    .data_we_o     (data_we_o),
    .busy_o        (busy_o),
    .data_addr_o   (data_addr_o),
    .data_wdata_o  (data_wdata_o),
    .data_be_o     (data_be_o),
    .core_bus      (core_bus.arbiter),
    .stream_bus    (stream_bus.arbiter)
  );

endmodule

// ==== sim/tb_lsu_tests.svh ====
/*
 * directed tests for the load/store unit
 * typed compare tasks, expected-value functions, access helpers
 */

`ifndef TB_LSU_TESTS_SVH
`define TB_LSU_TESTS_SVH

//////////////////////////////////////////////////////////////
// compare tasks

task automatic compare_word(input logic [`LSU_DATA_W-1:0] got,
                            input logic [`LSU_DATA_W-1:0] exp, input string what);
  chk_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("ERROR %0t: %s, got %h expected %h", $time, what, got, exp);
  end
endtask

task automatic compare_size_flag(input lsu_pkg::size_e size, input logic got,
                                 input logic exp, input string what);
  chk_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("ERROR %0t: %s for %s access, got %b expected %b",
             $time, what, size.name(), got, exp);
  end
endtask

task automatic compare_state(input lsu_pkg::stream_state_e got,
                             input lsu_pkg::stream_state_e exp, input string what);
  chk_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("ERROR %0t: %s, got %s expected %s", $time, what, got.name(), exp.name());
  end
endtask

task automatic report_test(input string name, input int c0, input int e0);
  $display("%s: %0d checks, %0d errors", name, chk_cnt - c0, err_cnt - e0);
endtask

//////////////////////////////////////////////////////////////
// expected values

function automatic bit is_aligned(input lsu_pkg::size_e size, input int off);
  if (size == lsu_pkg::SIZE_WORD) return off == 0;
  if (size == lsu_pkg::SIZE_HALF) return off != 3;  // must stay inside the word
  return 1'b1;
endfunction

// old word with the addressed lanes taken from the rotated register
function automatic logic [31:0] store_result(input logic [31:0] old_w, input logic [31:0] wd,
                                             input lsu_pkg::size_e size, input int off,
                                             input int ro);
  logic [31:0] res;
  int          src;
  res = old_w;
  for (int k = 0; k < 4; k++) begin
    if ((size == lsu_pkg::SIZE_WORD) || (k == off) ||
        ((size == lsu_pkg::SIZE_HALF) && (k == off + 1))) begin
      src = (k - off + ro) & 3;  // register byte landing on lane k
      res[8*k +: 8] = wd[8*src +: 8];
    end
  end
  return res;
endfunction

function automatic logic [31:0] load_result(input logic [31:0] word, input lsu_pkg::size_e size,
                                            input lsu_pkg::ext_e ext, input int off);
  logic [31:0] lane;
  logic        fill;
  lane = word >> (8 * off);
  if (size == lsu_pkg::SIZE_WORD) return word;
  if (size == lsu_pkg::SIZE_HALF) begin
    fill = (ext == lsu_pkg::EXT_ONES) || ((ext == lsu_pkg::EXT_SIGN) && lane[15]);
    return {{16{fill}}, lane[15:0]};
  end
  fill = (ext == lsu_pkg::EXT_ONES) || ((ext == lsu_pkg::EXT_SIGN) && lane[7]);
  return {{24{fill}}, lane[7:0]};
endfunction

//////////////////////////////////////////////////////////////
// access helpers

task automatic fill_mem();
  for (int i = 0; i < 256; i++) begin
    mem[i] = (i + 1) * 32'h9E37_79B1;  // spread over the whole word address
  end
endtask

// one core access through the base plus offset path
task automatic core_access(input logic we, input lsu_pkg::size_e size, input lsu_pkg::ext_e ext,
                           input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [1:0] ro, output logic [31:0] rdata);
  rdata = '0;
  @(negedge clk);
  ex_req_i     = 1'b1;
  ex_we_i      = we;
  ex_size_i    = size;
  ex_ext_i     = ext;
  op_a_i       = addr - 32'd12;
  op_b_i       = 32'd12;
  addr_incr_i  = 1'b1;
  ex_wdata_i   = wdata;
  reg_offset_i = ro;
  do begin
    @(posedge clk);
  end while (!ready_ex_o);  // accepted at this edge
  @(negedge clk);
  ex_req_i = 1'b0;
  if (!we) begin
    do begin
      @(posedge clk);
    end while (!wb_valid_o);
    rdata = wb_rdata_o;
  end
endtask

task automatic start_stream(input logic [31:0] base, input logic [15:0] len);
  @(negedge clk);
  stream_start_i = 1'b1;
  stream_base_i  = base;
  stream_len_i   = len;
  @(negedge clk);
  stream_start_i = 1'b0;
endtask

// words in address order, then done one cycle later and back to idle
task automatic collect_stream(input logic [31:0] base, input int len);
  int n;
  n = 0;
  while (n < len) begin
    @(posedge clk);
    if (stream_rvalid_o) begin
      compare_word(stream_rdata_o, mem[base[9:2] + n], $sformatf("stream word %0d", n));
      n++;
    end
  end
  @(posedge clk);
  compare_word(32'(stream_done_o), 32'd1, "stream done after last word");
  compare_state(i_load_store_unit.i_stream_gen.state_q, lsu_pkg::ST_IDLE,
                "stream state after done");
endtask

//////////////////////////////////////////////////////////////
// directed tests

task automatic test_stores();
  int             c0;
  int             e0;
  int             n;
  int             off;
  logic [31:0]    addr;
  logic [31:0]    old_w;
  logic [31:0]    wd;
  logic [31:0]    rd;
  lsu_pkg::size_e size;
  c0 = chk_cnt;
  e0 = err_cnt;
  n  = 0;
  for (int s = 0; s < 3; s++) begin
    size = lsu_pkg::size_e'(s);
    for (off = 0; off < 4; off++) begin
      if (!is_aligned(size, off)) continue;
      addr  = 32'h80 + 4 * n + off;  // fresh word per store
      old_w = mem[addr[9:2]];
      wd    = 32'hC3A5_1E00 + n * 32'h0101_0111;
      core_access(1'b1, size, lsu_pkg::EXT_ZERO, addr, wd, 2'(n), rd);
      compare_word(mem[addr[9:2]], store_result(old_w, wd, size, off, n % 4),
                   $sformatf("%s store at offset %0d", size.name(), off));
      n++;
    end
  end
  report_test("stores", c0, e0);
endtask

task automatic test_loads();
  int             c0;
  int             e0;
  int             off;
  logic [31:0]    rd;
  lsu_pkg::size_e size;
  lsu_pkg::ext_e  ext;
  c0 = chk_cnt;
  e0 = err_cnt;
  mem[16] = 32'h80FF_7F01;  // byte and half msbs mixed
  mem[17] = 32'h017F_80FE;
  for (int w = 16; w < 18; w++) begin
    for (int e = 0; e < 3; e++) begin
      ext = lsu_pkg::ext_e'(e);
      for (int s = 0; s < 3; s++) begin
        size = lsu_pkg::size_e'(s);
        for (off = 0; off < 4; off++) begin
          if (!is_aligned(size, off)) continue;
          core_access(1'b0, size, ext, 4 * w + off, '0, 2'b00, rd);
          compare_word(rd, load_result(mem[w], size, ext, off),
                       $sformatf("%s %s load at offset %0d", size.name(), ext.name(), off));
        end
      end
    end
  end
  report_test("loads", c0, e0);
endtask

task automatic test_misaligned();
  int             c0;
  int             e0;
  lsu_pkg::size_e size;
  logic [1:0]     off;
  c0 = chk_cnt;
  e0 = err_cnt;
  for (int k = 0; k < 4; k++) begin
    if (k < 3) begin
      size = lsu_pkg::SIZE_WORD;
      off  = 2'(k + 1);
    end else begin
      size = lsu_pkg::SIZE_HALF;
      off  = 2'd3;
    end
    @(negedge clk);
    ex_req_i    = 1'b1;
    ex_we_i     = k[0];  // loads and stores alike
    ex_size_i   = size;
    op_a_i      = 32'h40 + off;
    op_b_i      = '0;
    addr_incr_i = 1'b0;
    @(posedge clk);
    compare_size_flag(size, misaligned_o, 1'b1, "misaligned flag");
    compare_size_flag(size, ready_ex_o, 1'b1, "ready on misaligned");
    compare_size_flag(size, data_req_o, 1'b0, "bus request on misaligned");
  end
  @(negedge clk);
  ex_req_i = 1'b0;
  report_test("misaligned", c0, e0);
endtask

task automatic test_stream();
  int c0;
  int e0;
  c0 = chk_cnt;
  e0 = err_cnt;
  start_stream(32'h100, 16'd8);
  compare_state(i_load_store_unit.i_stream_gen.state_q, lsu_pkg::ST_ISSUE,
                "stream state after start");
  collect_stream(32'h100, 8);
  report_test("stream", c0, e0);
endtask

// core loads racing a stream under random grants
task automatic test_shared_bus();
  int             c0;
  int             e0;
  int             off;
  logic [31:0]    addr;
  logic [31:0]    exp;
  logic [31:0]    rd;
  lsu_pkg::size_e size;
  lsu_pkg::ext_e  ext;
  c0    = chk_cnt;
  e0    = err_cnt;
  bp_en = 1'b1;
  fork
    begin
      start_stream(32'h280, 16'd8);
      collect_stream(32'h280, 8);
    end
    begin
      repeat (2) @(negedge clk);
      for (int i = 0; i < 6; i++) begin
        size = lsu_pkg::size_e'(i % 3);
        ext  = lsu_pkg::ext_e'((i + 1) % 3);
        if (size == lsu_pkg::SIZE_WORD) begin
          off = 0;
        end else if (size == lsu_pkg::SIZE_HALF) begin
          off = i % 3;
        end else begin
          off = i % 4;
        end
        addr = 32'h40 + 4 * i + off;
        exp  = load_result(mem[addr[9:2]], size, ext, off);
        core_access(1'b0, size, ext, addr, '0, 2'b00, rd);
        compare_word(rd, exp, $sformatf("core load %0d during stream", i));
      end
    end
  join
  bp_en = 1'b0;
  @(posedge clk);
  compare_word(32'(busy_o), 32'd0, "busy after all traffic");
  report_test("shared bus", c0, e0);
endtask

`endif

// ==== sim/tb_load_store_unit.sv ====
/*
 * testbench top for the load/store unit
 * clock, reset, data memory model, lcg, timeout, DUT instance
 */

`include "lsu_consts.svh"

module tb_load_store_unit;

  localparam int          TIMEOUT_CYCLES = 2000;    // about 4x the longest test
  localparam logic [31:0] LCG_SEED       = 32'd19515;

  logic                   clk = 1'b0;
  logic                   rst_n;
  logic                   ex_req_i;
  logic                   ex_we_i;
  logic                   addr_incr_i;
  lsu_pkg::size_e         ex_size_i;
  lsu_pkg::ext_e          ex_ext_i;
  logic [`LSU_DATA_W-1:0] op_a_i;
  logic [`LSU_DATA_W-1:0] op_b_i;
  logic [`LSU_DATA_W-1:0] ex_wdata_i;
  logic [1:0]             reg_offset_i;
  logic                   ready_ex_o;
  logic                   misaligned_o;
  logic                   wb_valid_o;
  logic [`LSU_DATA_W-1:0] wb_rdata_o;
  logic                   stream_start_i;
  logic [`LSU_DATA_W-1:0] stream_base_i;
  logic [`LSU_LEN_W-1:0]  stream_len_i;
  logic                   stream_rvalid_o;
  logic                   stream_done_o;
  logic [`LSU_DATA_W-1:0] stream_rdata_o;
  logic                   data_req_o;
  logic                   data_gnt_i;
  logic                   data_rvalid_i;
  logic [`LSU_DATA_W-1:0] data_addr_o;
  logic                   data_we_o;
  logic [`LSU_BE_W-1:0]   data_be_o;
  logic [`LSU_DATA_W-1:0] data_wdata_o;
  logic [`LSU_DATA_W-1:0] data_rdata_i;
  logic                   busy_o;

  logic [`LSU_DATA_W-1:0] mem [0:255];  // word memory indexed by addr[9:2]
  logic [`LSU_DATA_W-1:0] resp_q [$];   // read data waiting for rvalid
  logic [7:0]             mem_idx;
  logic [31:0]            lcg_state;
  logic [31:0]            rnd;
  logic                   bp_en;        // random grant back-pressure
  int                     cycle_cnt;
  int                     chk_cnt;
  int                     err_cnt;

  load_store_unit i_load_store_unit (
    .clk             (clk),
    .rst_n           (rst_n),
    .ex_req_i        (ex_req_i),
    .ex_we_i         (ex_we_i),
    .addr_incr_i     (addr_incr_i),
    .ex_size_i       (ex_size_i),
    .ex_ext_i        (ex_ext_i),
    .op_a_i          (op_a_i),
    .op_b_i          (op_b_i),
    .ex_wdata_i      (ex_wdata_i),
    .reg_offset_i    (reg_offset_i),
    .ready_ex_o      (ready_ex_o),
    .misaligned_o    (misaligned_o),
    .wb_valid_o      (wb_valid_o),
    .wb_rdata_o      (wb_rdata_o),
    .stream_start_i  (stream_start_i),
    .stream_base_i   (stream_base_i),
    .stream_len_i    (stream_len_i),
    .stream_rvalid_o (stream_rvalid_o),
    .stream_done_o   (stream_done_o),
    .stream_rdata_o  (stream_rdata_o),
    .data_req_o      (data_req_o),
    .data_gnt_i      (data_gnt_i),
    .data_rvalid_i   (data_rvalid_i),
    .data_addr_o     (data_addr_o),
    .data_we_o       (data_we_o),
    .data_be_o       (data_be_o),
    .data_wdata_o    (data_wdata_o),
    .data_rdata_i    (data_rdata_i),
    .busy_o          (busy_o)
  );

  always #20 clk = ~clk;  // 40 unit period

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  ////////////////////////////////////////////////////////////
  // memory model

  // accept side with writes honouring byte enables
  always @(posedge clk) begin
    if (data_req_o && data_gnt_i) begin
      mem_idx = data_addr_o[9:2];
      if (data_we_o) begin
        for (int b = 0; b < `LSU_BE_W; b++) begin
          if (data_be_o[b]) mem[mem_idx][8*b +: 8] = data_wdata_o[8*b +: 8];
        end
      end
      resp_q.push_back(mem[mem_idx]);  // arbiter keeps at most two in flight
    end
  end

  // response one cycle after the grant and grant by lcg under back-pressure
  always @(negedge clk) begin
    rnd        = next_rand();
    data_gnt_i = bp_en ? rnd[16] : 1'b1;
    if (resp_q.size() > 0) begin
      data_rvalid_i = 1'b1;
      data_rdata_i  = resp_q.pop_front();
    end else begin
      data_rvalid_i = 1'b0;
      data_rdata_i  = '0;
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: tests still running after %0d cycles", cycle_cnt);
      $display("Checks failed");
      $finish;
    end
  end

  `include "tb_lsu_tests.svh"

  initial begin
    rst_n          = 1'b0;
    ex_req_i       = 1'b0;
    ex_we_i        = 1'b0;
    addr_incr_i    = 1'b0;
    ex_size_i      = lsu_pkg::SIZE_WORD;
    ex_ext_i       = lsu_pkg::EXT_ZERO;
    op_a_i         = '0;
    op_b_i         = '0;
    ex_wdata_i     = '0;
    reg_offset_i   = 2'b00;
    stream_start_i = 1'b0;
    stream_base_i  = '0;
    stream_len_i   = '0;
    data_gnt_i     = 1'b0;
    data_rvalid_i  = 1'b0;
    data_rdata_i   = '0;
    lcg_state      = LCG_SEED;
    bp_en          = 1'b0;
    cycle_cnt      = 0;
    chk_cnt        = 0;
    err_cnt        = 0;
    fill_mem();
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    test_stores();
    test_loads();
    test_misaligned();
    test_stream();
    test_shared_bus();

    $display("total: %0d checks, %0d errors", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== load_store_unit.f ====
+incdir+hw
+incdir+sim
hw/lsu_pkg.sv
hw/lsu_bus_if.sv
hw/lsu_core_port.sv
hw/lsu_stream_gen.sv
hw/lsu_bus_arbiter.sv
hw/load_store_unit.sv
sim/tb_load_store_unit.sv

// ==== Bender.yml ====
package:
  name: load_store_unit

sources:
  - include_dirs:
      - hw
    files:
      - hw/lsu_pkg.sv
      - hw/lsu_bus_if.sv
      - hw/lsu_core_port.sv
      - hw/lsu_stream_gen.sv
      - hw/lsu_bus_arbiter.sv
      - hw/load_store_unit.sv
  - target: simulation
    include_dirs:
      - hw
      - sim
    files:
      - sim/tb_load_store_unit.sv
